/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_sdram_ctrl
FILELIST  := project.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hw/sdram_app_port.sv */
// application command port; turns a command pulse and its write beats into one queued request
module sdram_app_port (
  input  logic                          clk0,
  input  logic                          rst_n,
  input  logic                          app_cmd_valid,
  input  logic                          app_cmd_rnw,
  input  logic [31:0]                   app_cmd_addr,
  input  logic [sdram_pkg::DATA_W-1:0]  app_wr_data,
  input  logic [sdram_pkg::BE_W-1:0]    app_wr_be,
  input  logic                          phy_rdy,
  output logic                          app_cmd_full,
  output logic                          port_req,
  input  logic                          port_ack,
  output sdram_pkg::sdram_req_t         port_item
);

  typedef enum logic [1:0] {P_IDLE, P_BEAT, P_REQ, P_REL} port_state_e;

  port_state_e state;
  logic        ready;
  logic        accept;

  // free once the queue has dropped ack on the last handshake
  assign ready        = (state == P_IDLE) || (state == P_REL && !port_ack);
  assign app_cmd_full = !phy_rdy || !ready;
  assign accept       = app_cmd_valid && !app_cmd_full;
  assign port_req     = (state == P_REQ);

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      state <= P_IDLE;
    end else if (accept) begin
      state <= app_cmd_rnw ? P_REQ : P_BEAT;   // writes wait for beat 2
    end else begin
      case (state)
        P_BEAT:  state <= P_REQ;
        P_REQ:   if (port_ack) state <= P_REL;
        P_REL:   if (!port_ack) state <= P_IDLE;
        default: state <= P_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk0) begin
    if (accept) begin
      port_item.rnw         <= app_cmd_rnw;
      port_item.addr.linear <= app_cmd_addr;
      port_item.data0       <= app_wr_data;
      port_item.be0         <= app_wr_be;
    end
    if (state == P_BEAT) begin
      port_item.data1 <= app_wr_data;   // second beat, cycle after the pulse
      port_item.be1   <= app_wr_be;
    end
  end

  a_no_pulse_when_full: assert property (
    @(posedge clk0) disable iff (!rst_n) app_cmd_valid |-> !app_cmd_full
  ) else $error("command pulse while app_cmd_full is high");

endmodule

/* hw/sdram_cmd_queue.sv */
// request FIFO between the application port and the sequencer, four-phase req/ack on both sides
module sdram_cmd_queue #(
  parameter int DEPTH = 4   // power of two
) (
  input  logic                  clk0,
  input  logic                  rst_n,
  input  logic                  port_req,
  output logic                  port_ack,
  input  sdram_pkg::sdram_req_t port_item,
  output logic                  seq_req,
  input  logic                  seq_ack,
  output sdram_pkg::sdram_req_t seq_item
);
  import sdram_pkg::*;

  localparam int AW = $clog2(DEPTH);

  sdram_req_t    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  // no ack while full, the port just keeps req up
  assign push     = port_req && !port_ack && (count != (AW + 1)'(DEPTH));
  assign pop      = seq_req && seq_ack;
  assign seq_item = mem[rd_ptr];

  always_ff @(posedge clk0) begin
    if (push) begin
      mem[wr_ptr] <= port_item;
    end
  end

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      port_ack <= 1'b0;
      seq_req  <= 1'b0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        port_ack <= 1'b1;
        wr_ptr   <= wr_ptr + 1'b1;   // wraps, depth is a power of two
      end else if (port_ack && !port_req) begin
        port_ack <= 1'b0;
      end

      if (pop) begin
        seq_req <= 1'b0;
        rd_ptr  <= rd_ptr + 1'b1;
      end else if (!seq_req && !seq_ack && count != '0) begin
        seq_req <= 1'b1;             // offer head once the last ack is gone
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge clk0) disable iff (!rst_n) count <= (AW + 1)'(DEPTH)
  ) else $error("queue count above DEPTH");

  // head must not move under a pending request
  a_head_stable: assert property (
    @(posedge clk0) disable iff (!rst_n) seq_req && !seq_ack |=> $stable(seq_item)
  ) else $error("seq_item changed while seq_req was high");

endmodule

/* hw/sdram_ctrl_top.sv */
// controller top level; ties application port, request queue and sequencer to the pins
module sdram_ctrl_top (
  input  logic                          clk0,
  input  logic                          rst_n,
  input  logic                          app_cmd_valid,
  input  logic                          app_cmd_rnw,
  input  logic [31:0]                   app_cmd_addr,
  input  logic [sdram_pkg::DATA_W-1:0]  app_wr_data,
  input  logic [sdram_pkg::BE_W-1:0]    app_wr_be,
  output logic                          app_cmd_full,
  output logic [sdram_pkg::DATA_W-1:0]  app_rd_data,
  output logic                          app_rd_valid,
  output logic                          phy_rdy,
  output logic                          dram_cs_n,
  output logic                          dram_ras_n,
  output logic                          dram_cas_n,
  output logic                          dram_we_n,
  output logic [sdram_pkg::BANK_W-1:0]  dram_ba,
  output logic [sdram_pkg::ROW_W-1:0]   dram_a,
  output logic [sdram_pkg::DATA_W-1:0]  dram_dq_out,
  output logic                          dram_dq_oe,
  output logic [sdram_pkg::BE_W-1:0]    dram_dm,
  input  logic [sdram_pkg::DATA_W-1:0]  dram_dq_in
);
  import sdram_pkg::*;

  logic       port_req;
  logic       port_ack;
  sdram_req_t port_item;
  logic       seq_req;
  logic       seq_ack;
  sdram_req_t seq_item;

  // port and link names match across all three blocks
  sdram_app_port  u_app_port  (.*);
  sdram_cmd_queue u_cmd_queue (.*);
  sdram_sequencer u_sequencer (.*);

endmodule

/* hw/sdram_pkg.sv */
// shared widths, memory timing, address and request types; imported by every controller module
package sdram_pkg;

  localparam int ROW_W  = 12;
  localparam int BANK_W = 2;
  localparam int COL_W  = 8;
  localparam int DATA_W = 32;
  localparam int BE_W   = 4;

  // memory timing in clk0 cycles
  localparam int TRCD_CYC  = 2;
  localparam int TRP_CYC   = 2;
  localparam int TRAS_CYC  = 5;
  localparam int TWR_CYC   = 2;
  localparam int TRFC_CYC  = 6;
  localparam int TREFI_CYC = 200;
  localparam int INIT_CYC  = 40;
  localparam int CAS_LAT   = 2;
  localparam int TMRD_CYC  = 2;     // load-mode to next command

  localparam int ACT2COL_CYC = TRCD_CYC + 1;   // ACT, then TRCD_CYC NOPs
  localparam int RD2PRE_CYC  = (TRAS_CYC > ACT2COL_CYC) ? TRAS_CYC - ACT2COL_CYC : 1;
  localparam int WR2PRE_CYC  = (TWR_CYC + 1 > RD2PRE_CYC) ? TWR_CYC + 1 : RD2PRE_CYC;
  // longest ACT..next command, bounds how late a pending refresh can go out
  localparam int MAX_ACCESS_CYC = ACT2COL_CYC + WR2PRE_CYC + TRP_CYC + 2;

  localparam int WAIT_W = 8;                      // holds INIT_CYC and every gap
  localparam int REFI_W = $clog2(TREFI_CYC + 1);

  // a[6:4] cas 2, a[3] sequential, a[2:0] burst of 2
  localparam logic [ROW_W-1:0] MODE_WORD = 12'h021;

  typedef struct packed {
    logic [31-ROW_W-BANK_W-COL_W:0] rsvd;
    logic [ROW_W-1:0]               row;
    logic [BANK_W-1:0]              bank;
    logic [COL_W-1:0]               col;     // bit 0 picks the beat
  } sdram_addr_fields_t;

  typedef union packed {
    logic [31:0]        linear;   // what the application drives
    sdram_addr_fields_t fields;   // what the sequencer decodes
  } sdram_addr_u;

  typedef struct packed {
    logic              rnw;
    sdram_addr_u       addr;
    logic [DATA_W-1:0] data0;
    logic [DATA_W-1:0] data1;
    logic [BE_W-1:0]   be0;
    logic [BE_W-1:0]   be1;
  } sdram_req_t;

  // encoded as {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    CMD_LMR = 3'b000,
    CMD_REF = 3'b001,
    CMD_PRE = 3'b010,
    CMD_ACT = 3'b011,
    CMD_WR  = 3'b100,
    CMD_RD  = 3'b101,
    CMD_NOP = 3'b111
  } sdram_cmd_e;

endpackage

/* hw/sdram_sequencer.sv */
// SDRAM command sequencer; power-up, periodic refresh and close-page accesses on the memory pins
module sdram_sequencer (
  input  logic                          clk0,
  input  logic                          rst_n,
  input  logic                          seq_req,
  output logic                          seq_ack,
  input  sdram_pkg::sdram_req_t         seq_item,
  output logic                          phy_rdy,
  output logic [sdram_pkg::DATA_W-1:0]  app_rd_data,
  output logic                          app_rd_valid,
  output logic                          dram_cs_n,
  output logic                          dram_ras_n,
  output logic                          dram_cas_n,
  output logic                          dram_we_n,
  output logic [sdram_pkg::BANK_W-1:0]  dram_ba,
  output logic [sdram_pkg::ROW_W-1:0]   dram_a,
  output logic [sdram_pkg::DATA_W-1:0]  dram_dq_out,
  output logic                          dram_dq_oe,
  output logic [sdram_pkg::BE_W-1:0]    dram_dm,
  input  logic [sdram_pkg::DATA_W-1:0]  dram_dq_in
);
  import sdram_pkg::*;

  // each state waits out the gap after the command that entered it
  typedef enum logic [3:0] {
    ST_INIT, ST_IPRE, ST_IREF1, ST_IREF2, ST_ILMR,
    ST_IDLE, ST_ACT, ST_COL, ST_PRE, ST_REF
  } seq_state_e;

  seq_state_e        state;
  sdram_cmd_e        cmd_q;
  sdram_req_t        cur;
  logic [WAIT_W-1:0] wait_cnt;
  logic [REFI_W-1:0] refi_cnt;
  logic              ref_pend;
  logic              wr_beat2;
  logic [CAS_LAT:0]  rd_sh;
  logic              wait_done;
  logic              take;
  logic              col_go;
  logic              rd_cap;
  logic              is_act;
  logic              is_col;
  logic              is_ref;

  assign wait_done = (wait_cnt == '0);
  assign take      = (state == ST_IDLE) && !ref_pend && seq_req && !seq_ack;
  assign col_go    = (state == ST_ACT) && wait_done;
  assign rd_cap    = rd_sh[CAS_LAT-1] | rd_sh[CAS_LAT];   // both beats of the burst
  assign {dram_ras_n, dram_cas_n, dram_we_n} = cmd_q;

  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_INIT;
      wait_cnt   <= WAIT_W'(INIT_CYC - 1);
      cmd_q      <= CMD_NOP;
      dram_cs_n  <= 1'b1;
      dram_ba    <= '0;
      dram_a     <= '0;
      dram_dq_oe <= 1'b0;
      wr_beat2   <= 1'b0;
      seq_ack    <= 1'b0;
      phy_rdy    <= 1'b0;
      refi_cnt   <= '0;
      ref_pend   <= 1'b0;
    end else begin
      cmd_q      <= CMD_NOP;     // deselected unless a command goes out
      dram_cs_n  <= 1'b1;
      dram_dq_oe <= wr_beat2;
      wr_beat2   <= 1'b0;
      if (!wait_done) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      if (seq_ack && !seq_req) begin
        seq_ack <= 1'b0;
      end
      if (phy_rdy) begin
        if (refi_cnt == REFI_W'(TREFI_CYC - 1)) begin
          refi_cnt <= '0;
          ref_pend <= 1'b1;
        end else begin
          refi_cnt <= refi_cnt + 1'b1;
        end
      end

      case (state)
        ST_INIT: if (wait_done) begin
          cmd_q      <= CMD_PRE;
          dram_cs_n  <= 1'b0;
          dram_a     <= ROW_W'(1 << 10);   // a10, all banks
          wait_cnt   <= WAIT_W'(TRP_CYC - 1);
          state      <= ST_IPRE;
        end
        ST_IPRE, ST_IREF1: if (wait_done) begin
          cmd_q      <= CMD_REF;
          dram_cs_n  <= 1'b0;
          wait_cnt   <= WAIT_W'(TRFC_CYC - 1);
          state      <= (state == ST_IPRE) ? ST_IREF1 : ST_IREF2;
        end
        ST_IREF2: if (wait_done) begin
          cmd_q      <= CMD_LMR;
          dram_cs_n  <= 1'b0;
          dram_ba    <= '0;
          dram_a     <= MODE_WORD;
          wait_cnt   <= WAIT_W'(TMRD_CYC - 1);
          state      <= ST_ILMR;
        end
        ST_ILMR: if (wait_done) begin
          phy_rdy    <= 1'b1;
          state      <= ST_IDLE;
        end
        ST_IDLE: begin
          if (ref_pend) begin
            cmd_q     <= CMD_REF;   // refresh wins over a waiting request
            dram_cs_n <= 1'b0;
            ref_pend  <= 1'b0;
            wait_cnt  <= WAIT_W'(TRFC_CYC - 1);
            state     <= ST_REF;
          end else if (take) begin
            cmd_q     <= CMD_ACT;
            dram_cs_n <= 1'b0;
            dram_ba   <= seq_item.addr.fields.bank;
            dram_a    <= seq_item.addr.fields.row;
            seq_ack   <= 1'b1;
            wait_cnt  <= WAIT_W'(ACT2COL_CYC - 1);
            state     <= ST_ACT;
          end
        end
        ST_ACT: if (col_go) begin
          cmd_q      <= cur.rnw ? CMD_RD : CMD_WR;
          dram_cs_n  <= 1'b0;
          dram_ba    <= cur.addr.fields.bank;
          // burst aligned column, a10 low so no auto precharge
          dram_a     <= ROW_W'({cur.addr.fields.col[COL_W-1:1], 1'b0});
          dram_dq_oe <= !cur.rnw;
          wr_beat2   <= !cur.rnw;
          wait_cnt   <= cur.rnw ? WAIT_W'(RD2PRE_CYC - 1) : WAIT_W'(WR2PRE_CYC - 1);
          state      <= ST_COL;
        end
        ST_COL: if (wait_done) begin
          cmd_q      <= CMD_PRE;
          dram_cs_n  <= 1'b0;
          dram_ba    <= cur.addr.fields.bank;
          dram_a     <= '0;                 // this bank only
          wait_cnt   <= WAIT_W'(TRP_CYC - 1);
          state      <= ST_PRE;
        end
        ST_PRE, ST_REF: if (wait_done) begin
          state      <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk0) begin
    if (take) begin
      cur <= seq_item;
    end
    if (col_go) begin
      dram_dq_out <= cur.data0;
      dram_dm     <= cur.rnw ? '0 : ~cur.be0;   // mask is active low enable
    end else if (wr_beat2) begin
      dram_dq_out <= cur.data1;
      dram_dm     <= ~cur.be1;
    end
    if (rd_cap) begin
      app_rd_data <= dram_dq_in;
    end
  end

  // read return, one cycle after each sampled beat
  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      rd_sh        <= '0;
      app_rd_valid <= 1'b0;
    end else begin
      rd_sh        <= {rd_sh[CAS_LAT-1:0], is_col && dram_we_n};
      app_rd_valid <= rd_cap;
    end
  end

  assign is_act = !dram_cs_n && (cmd_q == CMD_ACT);
  assign is_col = !dram_cs_n && (cmd_q == CMD_RD || cmd_q == CMD_WR);
  assign is_ref = !dram_cs_n && (cmd_q == CMD_REF);

  a_act_to_col: assert property (
    @(posedge clk0) disable iff (!rst_n) is_act |=> (!is_col) [*(TRCD_CYC - 1)]
  ) else $error("RD/WR closer than TRCD_CYC to ACT");

  a_refresh_late: assert property (
    @(posedge clk0) disable iff (!rst_n) $rose(ref_pend) |-> ##[1:MAX_ACCESS_CYC] is_ref
  ) else $error("refresh held off longer than one access");

endmodule

/* project.f */
hw/sdram_pkg.sv
hw/sdram_app_port.sv
hw/sdram_cmd_queue.sv
hw/sdram_sequencer.sv
hw/sdram_ctrl_top.sv
testbench/sdram_model.sv
testbench/tb_sdram_ctrl.sv

/* testbench/sdram_model.sv */
// behavioral SDRAM for simulation; decodes pin commands, stores masked writes, returns read bursts
module sdram_model (
  input  logic                          clk0,
  input  logic                          cs_n,
  input  logic                          ras_n,
  input  logic                          cas_n,
  input  logic                          we_n,
  input  logic [sdram_pkg::BANK_W-1:0]  ba,
  input  logic [sdram_pkg::ROW_W-1:0]   a,
  input  logic [sdram_pkg::DATA_W-1:0]  dq_out,
  input  logic                          dq_oe,
  input  logic [sdram_pkg::BE_W-1:0]    dm,
  output logic [sdram_pkg::DATA_W-1:0]  dq_in
);
  timeunit 1ns;
  timeprecision 100ps;
  import sdram_pkg::*;

  logic [31:0] store [logic [21:0]];   // key is {bank, row, col}
  logic [11:0] open_row [4];
  logic [21:0] wr_key;
  logic        wr_next;
  logic [21:0] rd_key;
  logic [3:0]  rd_wait;
  logic        rd_next;
  logic [2:0]  cmd;

  assign cmd = {ras_n, cas_n, we_n};

  // unwritten words read back as a pattern of their own address
  function automatic logic [31:0] peek(input logic [21:0] k);
    return store.exists(k) ? store[k] : (32'h5a000000 ^ {10'd0, k});
  endfunction

  function automatic void poke(input logic [21:0] k, input logic [31:0] d, input logic [3:0] m);
    logic [31:0] w;
    w = peek(k);
    for (int b = 0; b < 4; b++) begin
      if (!m[b]) w[8*b +: 8] = d[8*b +: 8];   // dm bit low writes the byte
    end
    store[k] = w;
  endfunction

  initial begin
    wr_next = 1'b0;
    rd_wait = '0;
    rd_next = 1'b0;
    dq_in   = '0;
  end

  always @(posedge clk0) begin
    if (wr_next && dq_oe) poke(wr_key, dq_out, dm);   // second write beat
    wr_next <= 1'b0;
    if (rd_next) dq_in <= peek(rd_key);
    rd_next <= 1'b0;
    if (rd_wait > 4'd1) begin
      rd_wait <= rd_wait - 4'd1;
    end else if (rd_wait == 4'd1) begin
      dq_in   <= peek({rd_key[21:1], 1'b0});
      rd_key  <= {rd_key[21:1], 1'b1};
      rd_next <= 1'b1;
      rd_wait <= '0;
    end
    if (!cs_n) begin
      if (cmd == CMD_ACT) open_row[ba] <= a;
      if (cmd == CMD_WR) begin
        if (dq_oe) poke({ba, open_row[ba], a[7:1], 1'b0}, dq_out, dm);
        wr_key  <= {ba, open_row[ba], a[7:1], 1'b1};
        wr_next <= 1'b1;
      end
      if (cmd == CMD_RD) begin
        rd_key  <= {ba, open_row[ba], a[7:1], 1'b0};
        rd_wait <= 4'(CAS_LAT - 1);
      end
    end
  end

endmodule

/* testbench/tb_sdram_ctrl.sv */
// testbench for the SDRAM controller; directed and random traffic checked by concurrent assertions
module tb_sdram_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import sdram_pkg::*;

  localparam int POOL       = 8;
  localparam int QDEPTH     = 4;
  localparam int NRAND      = 40;
  localparam int NCMD       = 2 * POOL + 2 + (QDEPTH + 2) + NRAND;
  localparam int ACCESS_CYC = TRCD_CYC + TRAS_CYC + TWR_CYC + TRP_CYC + 9;
  localparam int LIMIT_CYC  = NCMD * 40 + INIT_CYC + 200;

  logic        clk0, rst_n;
  logic        app_cmd_valid, app_cmd_rnw, app_cmd_full, app_rd_valid, phy_rdy;
  logic [31:0] app_cmd_addr, app_wr_data, app_rd_data;
  logic [3:0]  app_wr_be;
  logic        dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n, dram_dq_oe;
  logic [1:0]  dram_ba;
  logic [11:0] dram_a;
  logic [31:0] dram_dq_out, dram_dq_in;
  logic [3:0]  dram_dm;

  int          err_cnt = 0;
  int          seed = 32'h680baa21;
  logic [31:0] shadow [2 * POOL];
  logic [31:0] exp_mem [512];       // expected read beats in issue order
  logic [8:0]  exp_wr = '0;
  logic [8:0]  exp_rd;
  logic [2:0]  init_cmd [4];
  logic [11:0] lmr_a;
  int          init_n;
  int          since_ref;
  int          full_run;
  logic        saw_full = 1'b0;
  logic        init_ok, is_act, is_rd, is_wr, is_pre, is_ref, is_any;
  logic [2:0]  cmd;

  sdram_ctrl_top UUT (.*);

  sdram_model u_mem (
    .clk0, .cs_n(dram_cs_n), .ras_n(dram_ras_n), .cas_n(dram_cas_n), .we_n(dram_we_n),
    .ba(dram_ba), .a(dram_a), .dq_out(dram_dq_out), .dq_oe(dram_dq_oe), .dm(dram_dm),
    .dq_in(dram_dq_in)
  );

  initial begin
    clk0 = 1'b0;
    forever #10 clk0 = ~clk0;
  end

  assign cmd    = {dram_ras_n, dram_cas_n, dram_we_n};
  assign is_any = !dram_cs_n && cmd != CMD_NOP;
  assign is_act = !dram_cs_n && cmd == CMD_ACT;
  assign is_rd  = !dram_cs_n && cmd == CMD_RD;
  assign is_wr  = !dram_cs_n && cmd == CMD_WR;
  assign is_pre = !dram_cs_n && cmd == CMD_PRE;
  assign is_ref = !dram_cs_n && cmd == CMD_REF;
  assign init_ok = init_n == 4 && init_cmd[0] == CMD_PRE && init_cmd[1] == CMD_REF
                   && init_cmd[2] == CMD_REF && init_cmd[3] == CMD_LMR && lmr_a == MODE_WORD;

  task automatic record_error(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  always @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      init_n    <= 0;
      since_ref <= 0;
      full_run  <= 0;
      exp_rd    <= '0;
    end else begin
      if (!phy_rdy && is_any && init_n < 4) begin
        init_cmd[init_n] <= cmd;   // power-up command log
        init_n           <= init_n + 1;
        if (cmd == CMD_LMR) lmr_a <= dram_a;
      end
      since_ref <= is_ref ? 0 : since_ref + 1;
      if (app_rd_valid) exp_rd <= exp_rd + 9'd1;
      if (phy_rdy && app_cmd_full) begin
        full_run <= full_run + 1;
        if (full_run >= 4) saw_full <= 1'b1;   // port held past a write's own busy cycles
      end else begin
        full_run <= 0;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk0)
    !rst_n |-> dram_cs_n && cmd == CMD_NOP && !dram_dq_oe && !phy_rdy && !app_rd_valid)
    else record_error("memory pins not idle during reset");

  a_init_order: assert property (@(posedge clk0) disable iff (!rst_n) $rose(phy_rdy) |-> init_ok)
    else record_error("power-up sequence was not PRE, REF, REF, LMR");

  a_rd_data: assert property (@(posedge clk0) disable iff (!rst_n)
    app_rd_valid |-> exp_rd < exp_wr && app_rd_data == exp_mem[exp_rd])
    else record_error($sformatf(
      "CHECK FAILED time=%0t signal=app_rd_data expected=%h actual=%h",
      $time, exp_mem[$sampled(exp_rd)], $sampled(app_rd_data)));

  a_rd_latency: assert property (@(posedge clk0) disable iff (!rst_n)
    is_rd |-> ##(CAS_LAT + 1) app_rd_valid ##1 app_rd_valid)
    else record_error("read beats not returned CAS_LAT+1 cycles after RD");

  a_trcd: assert property (@(posedge clk0) disable iff (!rst_n)
    is_act |=> (!is_rd && !is_wr) [*TRCD_CYC])
    else record_error("RD or WR issued too soon after ACT");

  a_tras: assert property (@(posedge clk0) disable iff (!rst_n)
    is_act |=> !is_pre [*(TRAS_CYC - 1)])
    else record_error("PRE issued too soon after ACT");

  a_twr: assert property (@(posedge clk0) disable iff (!rst_n) is_wr |=> !is_pre [*TWR_CYC])
    else record_error("PRE issued too soon after the last write beat");

  a_trp: assert property (@(posedge clk0) disable iff (!rst_n)
    is_pre |=> !is_any [*(TRP_CYC - 1)])
    else record_error("command issued too soon after PRE");

  a_trfc: assert property (@(posedge clk0) disable iff (!rst_n)
    is_ref |=> !is_any [*(TRFC_CYC - 1)])
    else record_error("command issued too soon after REF");

  a_refi: assert property (@(posedge clk0) disable iff (!rst_n)
    since_ref <= TREFI_CYC + ACCESS_CYC)
    else record_error("refresh interval exceeded");

  initial begin
    repeat (LIMIT_CYC) @(posedge clk0);
    $display("timeout after %0d cycles, %0d errors", LIMIT_CYC, err_cnt);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] pool_addr(input int i);
    return (32'(i) << 12) | (32'(i & 3) << 8) | (32'(i) << 2);   // even column
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
                                        input logic [3:0] be);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) w[8*b +: 8] = d[8*b +: 8];
    end
    return w;
  endfunction

  task automatic send_cmd(input logic rnw, input int i, input logic [31:0] d0,
                          input logic [3:0] b0, input logic [31:0] d1, input logic [3:0] b1);
    while (app_cmd_full) @(negedge clk0);
    app_cmd_valid = 1'b1;
    app_cmd_rnw   = rnw;
    app_cmd_addr  = pool_addr(i);
    app_wr_data   = d0;
    app_wr_be     = b0;
    if (rnw) begin
      exp_mem[exp_wr]        = shadow[2 * i];
      exp_mem[exp_wr + 9'd1] = shadow[2 * i + 1];
      exp_wr                 = exp_wr + 9'd2;
    end else begin
      shadow[2 * i]     = merge(shadow[2 * i], d0, b0);
      shadow[2 * i + 1] = merge(shadow[2 * i + 1], d1, b1);
    end
    @(negedge clk0);
    app_cmd_valid = 1'b0;
    app_wr_data   = d1;   // second write beat
    app_wr_be     = b1;
    @(negedge clk0);
  endtask

  initial begin
    logic [31:0] r0, r1, r2;
    rst_n         = 1'b1;
    app_cmd_valid = 1'b0;
    app_cmd_rnw   = 1'b0;
    app_cmd_addr  = '0;
    app_wr_data   = '0;
    app_wr_be     = '0;
    for (int i = 0; i < 2 * POOL; i++) shadow[i] = '0;
    #5;
    rst_n = 1'b0;   // async assert ahead of the first rising edge
    repeat (10) @(posedge clk0);
    @(negedge clk0);
    rst_n = 1'b1;
    while (!phy_rdy) @(negedge clk0);

    for (int i = 0; i < POOL; i++) begin
      r0 = $random(seed);
      r1 = $random(seed);
      send_cmd(1'b0, i, r0, 4'hf, r1, 4'hf);
    end
    for (int i = 0; i < POOL; i++) send_cmd(1'b1, i, '0, '0, '0, '0);
    send_cmd(1'b0, 1, 32'hdeadbeef, 4'b0101, 32'hcafef00d, 4'b1010);
    send_cmd(1'b1, 1, '0, '0, '0, '0);
    for (int i = 0; i < QDEPTH + 2; i++) send_cmd(1'b1, i, '0, '0, '0, '0);
    for (int n = 0; n < NRAND; n++) begin
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      send_cmd(r2[8], int'(r2[2:0]), r0, r2[7:4], r1, r2[12:9]);
    end

    while (exp_rd != exp_wr) @(negedge clk0);
    repeat (5) @(negedge clk0);
    assert (saw_full) else record_error("app_cmd_full never held back a command on a full queue");
    $display("errors: %0d, reads returned: %0d beats", err_cnt, exp_rd);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
